// ==== pkt_fifo_macros.svh ====
`ifndef PKT_FIFO_MACROS_SVH
`define PKT_FIFO_MACROS_SVH

// --------------------------------------------------
// beat format
// --------------------------------------------------
`define PF_DATA_BYTES 8
`define PF_TID_WIDTH 4
`define PF_TDEST_WIDTH 4
`define PF_TUSER_WIDTH 8

// --------------------------------------------------
// buffering
// --------------------------------------------------
`define PF_FIFO_DEPTH 64
// free words left when the write side drops ready
`define PF_ALMOST_FULL_THRESH 4
`define PF_MAX_PKT_BEATS 16

// discard stage holds three maximum-length packets
`define PF_DISCARD_DEPTH (3 * `PF_MAX_PKT_BEATS)

`endif

// ==== pkt_fifo_pkg.sv ====
`default_nettype none

`include "pkt_fifo_macros.svh"

package pkt_fifo_pkg;

   // one stream beat, tlast in the top bit
   typedef struct packed {
      logic                              tlast;
      logic [`PF_TID_WIDTH-1:0]          tid;
      logic [`PF_TDEST_WIDTH-1:0]        tdest;
      logic [`PF_TUSER_WIDTH-1:0]        tuser;
      logic [`PF_DATA_BYTES-1:0]         tkeep;
      logic [`PF_DATA_BYTES-1:0][7:0]    tdata;
   } beat_t;

   // word count of the egress fifo, 0 up to full
   typedef logic [$clog2(`PF_FIFO_DEPTH + 1)-1:0] fifo_count_t;

   // index into the discard buffer
   typedef logic [$clog2(`PF_DISCARD_DEPTH)-1:0] disc_ptr_t;

   // probe counters
   typedef logic [31:0] pkt_count_t;
   typedef logic [39:0] byte_count_t;

   // discard stage ingress state
   typedef enum logic {
      st_accept = 1'b0,
      st_drop   = 1'b1
   } disc_state_t;

endpackage

`default_nettype wire

// ==== fifo_fwft_sync.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "pkt_fifo_macros.svh"

module fifo_fwft_sync (
   input  logic                      axi4s_out,
   input  logic                      rst_n,
   input  logic                      flush,

   input  logic                      wr,
   input  pkt_fifo_pkg::beat_t       wr_data,
   output pkt_fifo_pkg::fifo_count_t wr_count,
   output logic                      full,
   output logic                      oflow,

   input  logic                      rd,
   output pkt_fifo_pkg::beat_t       rd_data,
   output logic                      empty,
   output logic                      uflow
);
   import pkt_fifo_pkg::*;

   localparam int DEPTH = `PF_FIFO_DEPTH;
   // depth is a power of two, so the pointers wrap on their own
   localparam int PTR_W = $clog2(DEPTH);

   beat_t            mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic             wr_ok;
   logic             rd_ok;

   assign full  = (wr_count == fifo_count_t'(DEPTH));
   assign empty = (wr_count == '0);

   // writes while full and reads while empty are ignored
   assign wr_ok = wr && !full;
   assign rd_ok = rd && !empty;

   // head word falls through as soon as it is written
   assign rd_data = mem[rd_ptr];

   // --------------------------------------------------
   // storage
   // --------------------------------------------------
   always_ff @(posedge axi4s_out) begin
      if (wr_ok) begin
         mem[wr_ptr] <= wr_data;
      end
   end

   // --------------------------------------------------
   // pointers and occupancy
   // --------------------------------------------------
   always_ff @(posedge axi4s_out or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         wr_count <= '0;
      end else if (flush) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         wr_count <= '0;
      end else begin
         if (wr_ok) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_ok) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({wr_ok, rd_ok})
            2'b10:   wr_count <= wr_count + 1'b1;
            2'b01:   wr_count <= wr_count - 1'b1;
            default: wr_count <= wr_count;
         endcase
      end
   end

   // error pulses, one cycle each
   always_ff @(posedge axi4s_out or negedge rst_n) begin
      if (!rst_n) begin
         oflow <= 1'b0;
         uflow <= 1'b0;
      end else if (flush) begin
         oflow <= 1'b0;
         uflow <= 1'b0;
      end else begin
         oflow <= wr && full;
         uflow <= rd && empty;
      end
   end

   // the reader only pops while a word is presented
   a_no_uflow : assert property (@(posedge axi4s_out) disable iff (!rst_n) !uflow)
      else $error("fifo_fwft_sync: read issued while empty");

endmodule

`default_nettype wire

// ==== pkt_discard_ovfl.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "pkt_fifo_macros.svh"

module pkt_discard_ovfl (
   input  logic                axi4s_out,
   input  logic                rst_n,
   input  logic                flush,

   input  logic                in_valid,
   input  pkt_fifo_pkg::beat_t in_beat,

   output logic                disc_valid,
   input  logic                disc_ready,
   output pkt_fifo_pkg::beat_t disc_beat,

   output logic                accept_fire,
   output logic                lost_fire,
   output pkt_fifo_pkg::beat_t lost_beat
);
   import pkt_fifo_pkg::*;

   localparam int DEPTH = `PF_DISCARD_DEPTH;
   localparam int LVL_W = $clog2(DEPTH + 1);

   beat_t            mem [DEPTH];
   disc_state_t      state;
   disc_ptr_t        wr_ptr;
   disc_ptr_t        sop_ptr;
   disc_ptr_t        commit_ptr;
   disc_ptr_t        rd_ptr;
   // beats held in total, and the committed part of them
   logic [LVL_W-1:0] level;
   logic [LVL_W-1:0] cmt_cnt;
   logic [LVL_W-1:0] level_nxt;
   logic [LVL_W-1:0] cmt_nxt;
   logic [LVL_W-1:0] uncommitted;
   logic             buf_full;
   logic             store;
   logic             overflow;
   logic             commit;
   logic             rd_fire;

   function automatic disc_ptr_t ptr_inc(input disc_ptr_t p);
      if (p == disc_ptr_t'(DEPTH - 1)) begin
         return '0;
      end
      return p + 1'b1;
   endfunction

   function automatic disc_ptr_t ptr_add(input disc_ptr_t p, input logic [LVL_W-1:0] n);
      logic [LVL_W:0] sum;
      sum = p + n;
      if (sum >= (LVL_W + 1)'(DEPTH)) begin
         sum = sum - (LVL_W + 1)'(DEPTH);
      end
      return disc_ptr_t'(sum);
   endfunction

   // --------------------------------------------------
   // ingress side
   // --------------------------------------------------
   assign uncommitted = level - cmt_cnt;
   assign buf_full    = (level == LVL_W'(DEPTH));
   assign store       = in_valid && (state == st_accept) && !buf_full;
   assign overflow    = in_valid && (state == st_accept) && buf_full;
   assign commit      = store && in_beat.tlast;

   assign accept_fire = store;
   // a lost beat and the rest of its packet
   assign lost_fire   = in_valid && !store;
   assign lost_beat   = in_beat;

   // read side only sees committed beats
   assign disc_valid = (cmt_cnt != '0);
   assign disc_beat  = mem[rd_ptr];
   assign rd_fire    = disc_valid && disc_ready;

   always_comb begin
      level_nxt = level;
      cmt_nxt   = cmt_cnt;
      if (store) begin
         level_nxt = level_nxt + 1'b1;
      end
      if (overflow) begin
         level_nxt = level_nxt - uncommitted;
      end
      if (commit) begin
         cmt_nxt = cmt_nxt + uncommitted + 1'b1;
      end
      if (rd_fire) begin
         level_nxt = level_nxt - 1'b1;
         cmt_nxt   = cmt_nxt - 1'b1;
      end
   end

   always_ff @(posedge axi4s_out) begin
      if (store) begin
         mem[wr_ptr] <= in_beat;
      end
   end

   always_ff @(posedge axi4s_out or negedge rst_n) begin
      if (!rst_n) begin
         state      <= st_accept;
         wr_ptr     <= '0;
         sop_ptr    <= '0;
         commit_ptr <= '0;
         rd_ptr     <= '0;
         level      <= '0;
         cmt_cnt    <= '0;
      end else if (flush) begin
         state      <= st_accept;
         wr_ptr     <= '0;
         sop_ptr    <= '0;
         commit_ptr <= '0;
         rd_ptr     <= '0;
         level      <= '0;
         cmt_cnt    <= '0;
      end else begin
         level   <= level_nxt;
         cmt_cnt <= cmt_nxt;

         // first beat of a packet marks where a rewind goes
         if (store && (uncommitted == '0)) begin
            sop_ptr <= wr_ptr;
         end
         if (store) begin
            wr_ptr <= ptr_inc(wr_ptr);
         end else if (overflow && (uncommitted != '0)) begin
            wr_ptr <= sop_ptr;
         end
         if (commit) begin
            commit_ptr <= ptr_inc(wr_ptr);
         end
         if (rd_fire) begin
            rd_ptr <= ptr_inc(rd_ptr);
         end

         case (state)
            st_accept: begin
               if (overflow && !in_beat.tlast) begin
                  state <= st_drop;
               end
            end
            st_drop: begin
               if (in_valid && in_beat.tlast) begin
                  state <= st_accept;
               end
            end
            default: state <= st_accept;
         endcase
      end
   end

   // --------------------------------------------------
   // checks
   // --------------------------------------------------
   a_wr_behind_rd : assert property (@(posedge axi4s_out) disable iff (!rst_n)
      (level <= LVL_W'(DEPTH)) && (ptr_add(rd_ptr, level) == wr_ptr))
      else $error("pkt_discard_ovfl: write pointer passed the read pointer");

   a_commit_bound : assert property (@(posedge axi4s_out) disable iff (!rst_n)
      disc_valid |-> (cmt_cnt <= level) && (ptr_add(rd_ptr, cmt_cnt) == commit_ptr))
      else $error("pkt_discard_ovfl: beat offered beyond the committed pointer");

endmodule

`default_nettype wire

// ==== stream_probe.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "pkt_fifo_macros.svh"

module stream_probe #(
   // 0 counts accepted traffic, 1 counts lost traffic
   parameter bit OVFL_MODE = 1'b0
) (
   input  logic                      axi4s_out,
   input  logic                      rst_n,
   input  logic                      flush,
   input  logic                      fire,
   input  pkt_fifo_pkg::beat_t       beat,
   output pkt_fifo_pkg::pkt_count_t  pkt_count,
   output pkt_fifo_pkg::byte_count_t byte_count
);
   import pkt_fifo_pkg::*;

   localparam int KEEP_W = `PF_DATA_BYTES;
   localparam int ONES_W = $clog2(KEEP_W + 1);

   logic [ONES_W-1:0]               keep_ones;
   logic [$bits(byte_count_t):0]    byte_sum;

   // bytes carried by this beat
   always_comb begin
      keep_ones = '0;
      for (int i = 0; i < KEEP_W; i++) begin
         keep_ones = keep_ones + beat.tkeep[i];
      end
   end

   assign byte_sum = byte_count + keep_ones;

   // both counters stick at all ones
   always_ff @(posedge axi4s_out or negedge rst_n) begin
      if (!rst_n) begin
         pkt_count  <= '0;
         byte_count <= '0;
      end else if (flush) begin
         pkt_count  <= '0;
         byte_count <= '0;
      end else if (fire) begin
         byte_count <= byte_sum[$bits(byte_count_t)] ? '1 : byte_sum[$bits(byte_count_t)-1:0];
         if (beat.tlast && (pkt_count != '1)) begin
            pkt_count <= pkt_count + 1'b1;
         end
      end
   end

   // accepted beats always carry data, lost ones may be anything
   a_keep_legal : assert property (@(posedge axi4s_out) disable iff (!rst_n)
      (fire && !OVFL_MODE) |-> (beat.tkeep != '0))
      else $error("%s probe: beat with empty tkeep", OVFL_MODE ? "overflow" : "accepted");

endmodule

`default_nettype wire

// ==== axi4s_pkt_fifo_sync.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "pkt_fifo_macros.svh"

module axi4s_pkt_fifo_sync (
   input  logic                      axi4s_out,
   input  logic                      rst_n,
   input  logic                      flush,

   input  logic                      in_valid,
   input  pkt_fifo_pkg::beat_t       in_beat,

   output logic                      egress_valid,
   input  logic                      egress_ready,
   output pkt_fifo_pkg::beat_t       egress_beat,

   output logic                      oflow,
   output pkt_fifo_pkg::pkt_count_t  acc_pkts,
   output pkt_fifo_pkg::byte_count_t acc_bytes,
   output pkt_fifo_pkg::pkt_count_t  lost_pkts,
   output pkt_fifo_pkg::byte_count_t lost_bytes
);
   import pkt_fifo_pkg::*;

   // write side stays ready up to this many words
   localparam fifo_count_t READY_LIMIT =
      fifo_count_t'(`PF_FIFO_DEPTH - `PF_ALMOST_FULL_THRESH);

   logic        disc_valid;
   logic        disc_ready;
   beat_t       disc_beat;
   logic        accept_fire;
   logic        lost_fire;
   beat_t       lost_beat;

   logic        wr;
   fifo_count_t wr_count;
   logic        rd;
   logic        empty;

   // --------------------------------------------------
   // ingress discard and traffic probes
   // --------------------------------------------------
   pkt_discard_ovfl i_discard (
      .axi4s_out   (axi4s_out),
      .rst_n       (rst_n),
      .flush       (flush),
      .in_valid    (in_valid),
      .in_beat     (in_beat),
      .disc_valid  (disc_valid),
      .disc_ready  (disc_ready),
      .disc_beat   (disc_beat),
      .accept_fire (accept_fire),
      .lost_fire   (lost_fire),
      .lost_beat   (lost_beat)
   );

   stream_probe #(.OVFL_MODE(1'b0)) i_probe_acc (
      .axi4s_out  (axi4s_out),
      .rst_n      (rst_n),
      .flush      (flush),
      .fire       (accept_fire),
      .beat       (in_beat),
      .pkt_count  (acc_pkts),
      .byte_count (acc_bytes)
   );

   stream_probe #(.OVFL_MODE(1'b1)) i_probe_ovfl (
      .axi4s_out  (axi4s_out),
      .rst_n      (rst_n),
      .flush      (flush),
      .fire       (lost_fire),
      .beat       (lost_beat),
      .pkt_count  (lost_pkts),
      .byte_count (lost_bytes)
   );

   // --------------------------------------------------
   // egress fifo
   // --------------------------------------------------
   assign disc_ready = (wr_count <= READY_LIMIT);
   assign wr         = disc_valid && disc_ready;
   assign rd         = egress_ready && !empty;

   fifo_fwft_sync i_fifo (
      .axi4s_out (axi4s_out),
      .rst_n     (rst_n),
      .flush     (flush),
      .wr        (wr),
      .wr_data   (disc_beat),
      .wr_count  (wr_count),
      .full      (),
      .oflow     (oflow),
      .rd        (rd),
      .rd_data   (egress_beat),
      .empty     (empty),
      .uflow     ()
   );

   assign egress_valid = !empty;

   a_no_oflow : assert property (@(posedge axi4s_out) disable iff (!rst_n) !oflow)
      else $error("axi4s_pkt_fifo_sync: fifo overflow");

endmodule

`default_nettype wire

// ==== pkt_fifo_top.sv ====
`default_nettype none
`timescale 1ns/10ps

module pkt_fifo_top (
   input  logic                      axi4s_out,
   input  logic                      rst_n,
   input  logic                      flush,

   input  logic                      in_valid,
   input  pkt_fifo_pkg::beat_t       in_beat,

   output logic                      egress_valid,
   input  logic                      egress_ready,
   output pkt_fifo_pkg::beat_t       egress_beat,

   output logic                      oflow,
   output pkt_fifo_pkg::pkt_count_t  acc_pkts,
   output pkt_fifo_pkg::byte_count_t acc_bytes,
   output pkt_fifo_pkg::pkt_count_t  lost_pkts,
   output pkt_fifo_pkg::byte_count_t lost_bytes
);

   axi4s_pkt_fifo_sync i_pkt_fifo (
      .axi4s_out    (axi4s_out),
      .rst_n        (rst_n),
      .flush        (flush),
      .in_valid     (in_valid),
      .in_beat      (in_beat),
      .egress_valid (egress_valid),
      .egress_ready (egress_ready),
      .egress_beat  (egress_beat),
      .oflow        (oflow),
      .acc_pkts     (acc_pkts),
      .acc_bytes    (acc_bytes),
      .lost_pkts    (lost_pkts),
      .lost_bytes   (lost_bytes)
   );

endmodule

`default_nettype wire

// ==== tb_pkt_fifo.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "pkt_fifo_macros.svh"

module tb_pkt_fifo;
   import pkt_fifo_pkg::*;

   localparam int N_LIGHT   = 20;
   localparam int N_OVER    = 40;
   localparam int N_PRE     = 8;
   localparam int N_POST    = 10;
   localparam int N_PKTS    = N_LIGHT + N_OVER + N_PRE + N_POST;
   localparam int MAX_BEATS = N_PKTS * `PF_MAX_PKT_BEATS;

   logic        axi4s_out;
   logic        rst_n;
   logic        flush;
   logic        in_valid;
   beat_t       in_beat;
   logic        egress_valid;
   logic        egress_ready;
   beat_t       egress_beat;
   logic        oflow;
   pkt_count_t  acc_pkts;
   byte_count_t acc_bytes;
   pkt_count_t  lost_pkts;
   byte_count_t lost_bytes;

   // packet p owns beats pkt_start[p] up to pkt_start[p] + pkt_len[p] - 1
   beat_t  beats [MAX_BEATS];
   int     pkt_start [N_PKTS];
   int     pkt_len [N_PKTS];
   int     pkt_gap [N_PKTS];
   int     pkt_bytes [N_PKTS];
   int     total_beats;
   int     sent_q [$];
   int     sent_cnt;
   longint sent_bytes;

   integer seed;
   int     error_count;
   int     cycle_count;
   int     cycle_limit;
   logic   light_phase;
   logic   stall_mode;
   logic   stall_low;
   int     burst_left;

   // egress monitor state
   logic   rx_active;
   int     rx_id;
   int     rx_idx;
   int     rx_pkts;
   int     skipped;
   beat_t  exp_beat;

   pkt_fifo_top i_dut (
      .axi4s_out    (axi4s_out),
      .rst_n        (rst_n),
      .flush        (flush),
      .in_valid     (in_valid),
      .in_beat      (in_beat),
      .egress_valid (egress_valid),
      .egress_ready (egress_ready),
      .egress_beat  (egress_beat),
      .oflow        (oflow),
      .acc_pkts     (acc_pkts),
      .acc_bytes    (acc_bytes),
      .lost_pkts    (lost_pkts),
      .lost_bytes   (lost_bytes)
   );

   always #2 axi4s_out = ~axi4s_out;

   // --------------------------------------------------
   // stimulus helpers
   // --------------------------------------------------
   task automatic build_packets();
      logic [31:0] r;
      logic [31:0] r2;
      int          pos;
      int          len;
      int          shift;
      beat_t       b;
      pos = 0;
      for (int p = 0; p < N_PKTS; p++) begin
         r = $random(seed);
         len = int'(r % `PF_MAX_PKT_BEATS) + 1;
         shift = int'(r[10:8]);
         pkt_start[p] = pos;
         pkt_len[p] = len;
         // last beat keeps 8 - shift bytes, the others are full
         pkt_bytes[p] = (len - 1) * `PF_DATA_BYTES + (`PF_DATA_BYTES - shift);
         if (p < N_LIGHT) begin
            pkt_gap[p] = 1 + int'(r[18:16] % 6);
         end else if (p < N_LIGHT + N_OVER) begin
            pkt_gap[p] = int'(r[16]);
         end else begin
            pkt_gap[p] = 1 + int'(r[17:16]);
         end
         for (int i = 0; i < len; i++) begin
            r = $random(seed);
            r2 = $random(seed);
            b.tlast = (i == len - 1);
            b.tid   = r[3:0];
            b.tdest = r[7:4];
            b.tuser = r[15:8];
            b.tkeep = b.tlast ? (8'hff >> shift) : 8'hff;
            // packet id rides in the top data bits
            b.tdata = {p[15:0], r2, r[31:16]};
            beats[pos] = b;
            pos++;
         end
      end
      total_beats = pos;
   endtask

   // advance one cycle, then update the back-pressure pattern
   task automatic tick();
      logic [31:0] r;
      @(posedge axi4s_out);
      #1;
      if (stall_mode) begin
         if (burst_left == 0) begin
            r = $random(seed);
            stall_low = !stall_low;
            burst_left = stall_low ? 40 + int'(r[5:0]) : 8 + int'(r[3:0]);
         end else begin
            burst_left--;
         end
         egress_ready = !stall_low;
      end
   endtask

   task automatic send_packet(input int p);
      sent_q.push_back(p);
      sent_cnt++;
      sent_bytes += pkt_bytes[p];
      for (int i = 0; i < pkt_len[p]; i++) begin
         in_valid = 1'b1;
         in_beat = beats[pkt_start[p] + i];
         tick();
      end
      in_valid = 1'b0;
      for (int g = 0; g < pkt_gap[p]; g++) begin
         tick();
      end
   endtask

   // open egress and wait for the output to stay quiet
   task automatic drain();
      int quiet;
      quiet = 0;
      stall_mode = 1'b0;
      egress_ready = 1'b1;
      while (quiet < 8) begin
         tick();
         if (egress_valid) begin
            quiet = 0;
         end else begin
            quiet++;
         end
      end
      assert (!rx_active) else begin
         error_count++;
         $display("[ERROR] %0t egress stopped in the middle of a packet", $time);
      end
   endtask

   // --------------------------------------------------
   // checks
   // --------------------------------------------------
   task automatic check_equal(input string name, input longint got, input longint exp);
      assert (got == exp) else begin
         error_count++;
         $display("[ERROR] %0t %s: got %0d expected %0d", $time, name, got, exp);
      end
   endtask

   task automatic check_idle();
      check_equal("egress_valid", longint'(egress_valid), 0);
      check_equal("acc_pkts", longint'(acc_pkts), 0);
      check_equal("acc_bytes", longint'(acc_bytes), 0);
      check_equal("lost_pkts", longint'(lost_pkts), 0);
      check_equal("lost_bytes", longint'(lost_bytes), 0);
   endtask

   task automatic check_counters();
      check_equal("acc_pkts + lost_pkts",
         longint'(acc_pkts) + longint'(lost_pkts), longint'(sent_cnt));
      check_equal("acc_bytes + lost_bytes",
         longint'(acc_bytes) + longint'(lost_bytes), sent_bytes);
      check_equal("acc_pkts", longint'(acc_pkts), longint'(rx_pkts));
   endtask

   a_egress_hold : assert property (@(posedge axi4s_out) disable iff (!rst_n)
      (egress_valid && !egress_ready && !flush) |=> (egress_valid && $stable(egress_beat)))
      else begin
         error_count++;
         $display("[ERROR] %0t egress_valid or egress_beat changed while stalled", $time);
      end

   a_no_oflow : assert property (@(posedge axi4s_out) disable iff (!rst_n) !oflow)
      else begin
         error_count++;
         $display("[ERROR] %0t oflow: got 1 expected 0", $time);
      end

   a_light_no_loss : assert property (@(posedge axi4s_out) disable iff (!rst_n)
      light_phase |-> (lost_pkts == '0))
      else begin
         error_count++;
         $display("[ERROR] %0t lost_pkts: got %0d expected 0", $time, lost_pkts);
      end

   // match each egress packet against the oldest pending sent packet
   always @(posedge axi4s_out) begin
      if (!rst_n || flush) begin
         rx_active = 1'b0;
         rx_idx = 0;
         rx_pkts = 0;
      end else if (egress_valid && egress_ready) begin
         if (!rx_active) begin
            // top two data bytes carry the packet id
            rx_id = int'(egress_beat.tdata[7:6]);
            skipped = 0;
            while ((sent_q.size() > 0) && (sent_q[0] != rx_id)) begin
               void'(sent_q.pop_front());
               skipped++;
            end
            if (sent_q.size() == 0) begin
               error_count++;
               $display("[ERROR] %0t egress packet %0d matches no pending packet", $time, rx_id);
            end else begin
               void'(sent_q.pop_front());
               rx_active = 1'b1;
               rx_idx = 0;
            end
            if (light_phase) begin
               assert (skipped == 0) else begin
                  error_count++;
                  $display("[ERROR] %0t skipped packets: got %0d expected 0", $time, skipped);
               end
            end
         end
         if (rx_active) begin
            if (rx_idx >= pkt_len[rx_id]) begin
               error_count++;
               $display("[ERROR] %0t egress packet %0d runs past its length", $time, rx_id);
            end else begin
               exp_beat = beats[pkt_start[rx_id] + rx_idx];
               assert (egress_beat == exp_beat) else begin
                  error_count++;
                  $display("[ERROR] %0t egress_beat: got %h expected %h",
                     $time, egress_beat, exp_beat);
               end
            end
            rx_idx++;
            if (egress_beat.tlast) begin
               rx_active = 1'b0;
               rx_pkts++;
            end
         end
      end
   end

   always @(posedge axi4s_out) begin
      cycle_count++;
      if (cycle_count > cycle_limit) begin
         $display("timeout after %0d cycles, errors: %0d", cycle_limit, error_count);
         $display("Simulation finished: FAIL");
         $finish;
      end
   end

   // --------------------------------------------------
   // test sequence
   // --------------------------------------------------
   initial begin
      seed = 32'h16c935a2;
      axi4s_out = 1'b0;
      rst_n = 1'b0;
      flush = 1'b0;
      in_valid = 1'b0;
      in_beat = '0;
      egress_ready = 1'b0;
      light_phase = 1'b0;
      stall_mode = 1'b0;
      stall_low = 1'b0;
      burst_left = 0;
      sent_cnt = 0;
      sent_bytes = 0;
      error_count = 0;
      cycle_count = 0;
      cycle_limit = 1000000;
      build_packets();
      cycle_limit = 2 * total_beats + 2000;

      repeat (3) @(posedge axi4s_out);
      #1;
      rst_n = 1'b1;
      check_idle();

      // light load, output always open
      light_phase = 1'b1;
      egress_ready = 1'b1;
      for (int p = 0; p < N_LIGHT; p++) begin
         send_packet(p);
      end
      drain();
      light_phase = 1'b0;
      check_counters();

      // overload with long stalls on egress
      stall_mode = 1'b1;
      for (int p = N_LIGHT; p < N_LIGHT + N_OVER; p++) begin
         send_packet(p);
      end
      drain();
      check_counters();
      assert (lost_pkts != '0) else begin
         error_count++;
         $display("[ERROR] %0t overload phase dropped no packet", $time);
      end

      // fill while stalled, then flush mid-run
      egress_ready = 1'b0;
      for (int p = N_LIGHT + N_OVER; p < N_LIGHT + N_OVER + N_PRE; p++) begin
         send_packet(p);
      end
      flush = 1'b1;
      sent_q.delete();
      sent_cnt = 0;
      sent_bytes = 0;
      tick();
      flush = 1'b0;
      check_idle();

      light_phase = 1'b1;
      egress_ready = 1'b1;
      for (int p = N_LIGHT + N_OVER + N_PRE; p < N_PKTS; p++) begin
         send_packet(p);
      end
      drain();
      light_phase = 1'b0;
      check_counters();

      $display("errors: %0d", error_count);
      if (error_count == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+.
pkt_fifo_pkg.sv
fifo_fwft_sync.sv
pkt_discard_ovfl.sv
stream_probe.sv
axi4s_pkt_fifo_sync.sv
pkt_fifo_top.sv
tb_pkt_fifo.sv
